// ==== include/ooo_params.svh ====
// PRF_SZ, ROB_SZ and PRF_SZ - ARCH_REGS must be powers of two and the free list must hold ROB_SZ
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

////////////////////////////////////////
// Register counts
////////////////////////////////////////
`define ARCH_REGS 32
`define ZERO_REG  31  // Architectural register that reads zero

`define PRF_SZ    64
`define ZERO_PRF  31  // Never allocated or freed

////////////////////////////////////////
// Buffer depth and word width
////////////////////////////////////////
`define ROB_SZ    16
`define DATA_W    64

// Run status encodings
`define NO_ERROR          4'h0
`define HALTED_ON_HALT    4'h2
`define HALTED_ON_ILLEGAL 4'h3

`endif

// ==== source/isa_pkg.sv ====
// Instruction kinds and run status as seen by retire only, with no decode fields
`default_nettype none

`include "ooo_params.svh"

package isa_pkg;

  // Kind of a dispatched instruction
  typedef enum logic [1:0] {
    INST_NORMAL  = 2'd0,
    INST_HALT    = 2'd1,
    INST_ILLEGAL = 2'd2
  } inst_kind_e;

  // Sticky run status
  typedef enum logic [3:0] {
    ERR_NONE              = `NO_ERROR,
    ERR_HALTED_ON_HALT    = `HALTED_ON_HALT,
    ERR_HALTED_ON_ILLEGAL = `HALTED_ON_ILLEGAL
  } error_status_e;

  typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;  // Architectural register index

endpackage

`default_nettype wire

// ==== source/ooo_pkg.sv ====
// Machine-side index and data types sized from the params header
`default_nettype none

`include "ooo_params.svh"

package ooo_pkg;

  // Physical register index
  typedef logic [$clog2(`PRF_SZ)-1:0] preg_t;

  // Reorder buffer slot
  typedef logic [$clog2(`ROB_SZ)-1:0] rob_idx_t;

  typedef logic [`DATA_W-1:0] word_t;  // Register and NPC word

endpackage

`default_nettype wire

// ==== source/rename_map.sv ====
// One rename and one free per cycle with a free list that never underflows under ROB back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module rename_map
  import isa_pkg::*;
  import ooo_pkg::*;
(
  input  logic  clock,
  input  logic  rst,
  input  logic  dispatch_fire,
  input  areg_t dispatch_dest,
  input  logic  retire_fire,
  input  preg_t retire_old_pdest,
  output preg_t new_pdest,
  output preg_t old_pdest
);

  localparam int FL_SZ = `PRF_SZ - `ARCH_REGS;
  localparam int FL_W  = $clog2(FL_SZ);

  preg_t           map_table [`ARCH_REGS];
  preg_t           free_list [FL_SZ];
  logic [FL_W-1:0] fl_head;
  logic [FL_W-1:0] fl_tail;
  logic [FL_W:0]   fl_count;
  logic            dest_is_zero;
  logic            rename_en;
  logic            free_en;

  ////////////////////////////////////////
  // Combinational rename
  ////////////////////////////////////////
  assign dest_is_zero = (dispatch_dest == areg_t'(`ZERO_REG));
  assign rename_en    = dispatch_fire && !dest_is_zero;
  assign free_en      = retire_fire && (retire_old_pdest != preg_t'(`ZERO_PRF));

  // Zero register bypasses the tables entirely
  assign new_pdest = dest_is_zero ? preg_t'(`ZERO_PRF) : free_list[fl_head];
  assign old_pdest = dest_is_zero ? preg_t'(`ZERO_PRF) : map_table[dispatch_dest];

  ////////////////////////////////////////
  // Map table and free list update
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      // Identity map, spare registers queued in ascending order
      for (int r = 0; r < `ARCH_REGS; r++)
      begin
        map_table[r] <= preg_t'(r);
      end
      for (int i = 0; i < FL_SZ; i++)
      begin
        free_list[i] <= preg_t'(`ARCH_REGS + i);
      end
      fl_head  <= '0;
      fl_tail  <= '0;
      fl_count <= (FL_W+1)'(FL_SZ);
    end
    else
    begin
      if (rename_en)
      begin
        map_table[dispatch_dest] <= free_list[fl_head];
        fl_head                  <= fl_head + 1'b1;  // Pop
      end
      if (free_en)
      begin
        free_list[fl_tail] <= retire_old_pdest;
        fl_tail            <= fl_tail + 1'b1;      // Push
      end
      if (free_en && !rename_en)
      begin
        fl_count <= fl_count + 1'b1;
      end
      else if (rename_en && !free_en)
      begin
        fl_count <= fl_count - 1'b1;
      end
    end
  end

  // ROB depth must keep enough registers free
  a_fl_not_empty: assert property (@(posedge clock) disable iff (rst)
    rename_en |-> (fl_count != '0));

endmodule

`default_nettype wire

// ==== source/reorder_buffer.sv ====
// One dispatch, one completion and one retire per cycle and completions must target live normal entries
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module reorder_buffer
  import isa_pkg::*;
  import ooo_pkg::*;
(
  input  logic       clock,
  input  logic       rst,
  input  logic       dispatch_valid,
  input  inst_kind_e dispatch_kind,
  input  areg_t      dispatch_dest,
  input  word_t      dispatch_npc,
  input  preg_t      new_pdest,
  input  preg_t      old_pdest,
  input  logic       complete_valid,
  input  rob_idx_t   complete_rob_idx,
  input  logic       halted,
  output logic       dispatch_stall,
  output logic       dispatch_fire,
  output rob_idx_t   dispatch_rob_idx,
  output preg_t      complete_pdest,
  output logic       commit_valid,
  output inst_kind_e commit_kind,
  output areg_t      commit_wr_idx,
  output preg_t      commit_pdest,
  output preg_t      retire_old_pdest,
  output word_t      commit_npc,
  output logic       commit_wr_en
);

  localparam int CNT_W = $clog2(`ROB_SZ + 1);

  // Per-entry payload
  inst_kind_e         entry_kind      [`ROB_SZ];
  areg_t              entry_dest      [`ROB_SZ];
  preg_t              entry_pdest     [`ROB_SZ];
  preg_t              entry_old_pdest [`ROB_SZ];
  word_t              entry_npc       [`ROB_SZ];
  logic [`ROB_SZ-1:0] entry_done;

  rob_idx_t   head;
  rob_idx_t   tail;
  logic [CNT_W-1:0] count;
  rob_idx_t   complete_offset;

  ////////////////////////////////////////
  // Dispatch side
  ////////////////////////////////////////
  assign dispatch_stall   = (count == CNT_W'(`ROB_SZ));  // All entries occupied
  assign dispatch_fire    = dispatch_valid && !dispatch_stall;
  assign dispatch_rob_idx = tail;

  // Destination of the completing entry for the register file write
  assign complete_pdest = entry_pdest[complete_rob_idx];

  ////////////////////////////////////////
  // Retire side
  ////////////////////////////////////////
  assign commit_valid     = (count != '0) && entry_done[head] && !halted;
  assign commit_kind      = entry_kind[head];
  assign commit_wr_idx    = entry_dest[head];
  assign commit_pdest     = entry_pdest[head];
  assign retire_old_pdest = entry_old_pdest[head];
  assign commit_npc       = entry_npc[head];
  assign commit_wr_en     = commit_valid && (entry_kind[head] == INST_NORMAL)
                            && (entry_pdest[head] != preg_t'(`ZERO_PRF));

  // Payload written at dispatch
  always_ff @(posedge clock)
  begin
    if (dispatch_fire)
    begin
      entry_kind[tail]      <= dispatch_kind;
      entry_dest[tail]      <= dispatch_dest;
      entry_pdest[tail]     <= new_pdest;
      entry_old_pdest[tail] <= old_pdest;
      entry_npc[tail]       <= dispatch_npc;
    end
  end

  // Pointers, occupancy and done bits
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      entry_done <= '0;
    end
    else
    begin
      if (dispatch_fire)
      begin
        tail             <= tail + 1'b1;
        entry_done[tail] <= (dispatch_kind != INST_NORMAL);  // Halt and illegal need no result
      end
      if (complete_valid)
      begin
        entry_done[complete_rob_idx] <= 1'b1;
      end
      if (commit_valid)
      begin
        head <= head + 1'b1;
      end
      if (dispatch_fire && !commit_valid)
      begin
        count <= count + 1'b1;
      end
      else if (commit_valid && !dispatch_fire)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // Distance from head tells whether a slot is in flight
  assign complete_offset = complete_rob_idx - head;

  a_complete_in_flight: assert property (@(posedge clock) disable iff (rst)
    complete_valid |-> (CNT_W'(complete_offset) < count));

  a_complete_once: assert property (@(posedge clock) disable iff (rst)
    complete_valid |-> !entry_done[complete_rob_idx]);

endmodule

`default_nettype wire

// ==== source/phys_regfile.sv ====
// Contents are undefined after reset until a completion writes them and ZERO_PRF always reads zero
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module phys_regfile
  import ooo_pkg::*;
(
  input  logic  clock,
  input  logic  complete_valid,
  input  preg_t complete_pdest,
  input  word_t complete_value,
  input  preg_t commit_pdest,
  output word_t commit_wr_data
);

  word_t regs [`PRF_SZ];

  ////////////////////////////////////////
  // Completion write port
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (complete_valid && (complete_pdest != preg_t'(`ZERO_PRF)))
    begin
      regs[complete_pdest] <= complete_value;
    end
  end

  ////////////////////////////////////////
  // Commit read port
  ////////////////////////////////////////
  always_comb
  begin
    if (commit_pdest == preg_t'(`ZERO_PRF))
    begin
      commit_wr_data = '0;  // Hardwired zero
    end
    else
    begin
      commit_wr_data = regs[commit_pdest];
    end
  end

endmodule

`default_nettype wire

// ==== source/retire_status.sv ====
// Status is sticky until reset and the 16-bit retire count wraps silently
`timescale 1ns/1ps
`default_nettype none

module retire_status
  import isa_pkg::*;
(
  input  logic          clock,
  input  logic          rst,
  input  logic          commit_valid,
  input  inst_kind_e    commit_kind,
  output logic          halted,
  output error_status_e error_status,
  output logic [15:0]   completed_insts
);

  ////////////////////////////////////////
  // Run status and retire count
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      error_status    <= ERR_NONE;
      completed_insts <= '0;
    end
    else if (commit_valid)
    begin
      case (commit_kind)
        INST_HALT:
        begin
          error_status    <= ERR_HALTED_ON_HALT;
          completed_insts <= completed_insts + 1'b1;  // Halt counts as done
        end
        INST_ILLEGAL:
        begin
          error_status <= ERR_HALTED_ON_ILLEGAL;  // Not counted
        end
        default:
        begin
          completed_insts <= completed_insts + 1'b1;
        end
      endcase
    end
  end

  // Any error stops retirement
  assign halted = (error_status != ERR_NONE);

endmodule

`default_nettype wire

// ==== source/ooo_retire_core.sv ====
// Scalar rename and retire only with completions supplied from outside and no recovery path
`timescale 1ns/1ps
`default_nettype none

module ooo_retire_core
  import isa_pkg::*;
  import ooo_pkg::*;
(
  input  logic          clock,
  input  logic          rst,
  // Dispatch
  input  logic          dispatch_valid,
  input  inst_kind_e    dispatch_kind,
  input  areg_t         dispatch_dest,
  input  word_t         dispatch_npc,
  output logic          dispatch_stall,
  output rob_idx_t      dispatch_rob_idx,
  // Completion bus
  input  logic          complete_valid,
  input  rob_idx_t      complete_rob_idx,
  input  word_t         complete_value,
  // Commit
  output logic          commit_valid,
  output logic          commit_wr_en,
  output areg_t         commit_wr_idx,
  output word_t         commit_wr_data,
  output word_t         commit_npc,
  output error_status_e error_status,
  output logic [15:0]   completed_insts
);

  logic       dispatch_fire;
  preg_t      new_pdest;
  preg_t      old_pdest;
  preg_t      complete_pdest;
  inst_kind_e commit_kind;
  preg_t      commit_pdest;
  preg_t      retire_old_pdest;
  logic       halted;

  ////////////////////////////////////////
  // Rename, buffer, registers, status
  ////////////////////////////////////////
  rename_map rename_map_i (
    .clock            (clock),
    .rst              (rst),
    .dispatch_fire    (dispatch_fire),
    .dispatch_dest    (dispatch_dest),
    .retire_fire      (commit_valid),
    .retire_old_pdest (retire_old_pdest),
    .new_pdest        (new_pdest),
    .old_pdest        (old_pdest)
  );

  reorder_buffer reorder_buffer_i (
    .clock            (clock),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_kind    (dispatch_kind),
    .dispatch_dest    (dispatch_dest),
    .dispatch_npc     (dispatch_npc),
    .new_pdest        (new_pdest),
    .old_pdest        (old_pdest),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .halted           (halted),
    .dispatch_stall   (dispatch_stall),
    .dispatch_fire    (dispatch_fire),
    .dispatch_rob_idx (dispatch_rob_idx),
    .complete_pdest   (complete_pdest),
    .commit_valid     (commit_valid),
    .commit_kind      (commit_kind),
    .commit_wr_idx    (commit_wr_idx),
    .commit_pdest     (commit_pdest),
    .retire_old_pdest (retire_old_pdest),
    .commit_npc       (commit_npc),
    .commit_wr_en     (commit_wr_en)
  );

  phys_regfile phys_regfile_i (
    .clock          (clock),
    .complete_valid (complete_valid),
    .complete_pdest (complete_pdest),
    .complete_value (complete_value),
    .commit_pdest   (commit_pdest),
    .commit_wr_data (commit_wr_data)
  );

  retire_status retire_status_i (
    .clock           (clock),
    .rst             (rst),
    .commit_valid    (commit_valid),
    .commit_kind     (commit_kind),
    .halted          (halted),
    .error_status    (error_status),
    .completed_insts (completed_insts)
  );

endmodule

`default_nettype wire

// ==== dv/ooo_retire_core_tb.sv ====
// Completions target only live normal entries and stimulus comes from a fixed-seed LCG
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module ooo_retire_core_tb
  import isa_pkg::*;
  import ooo_pkg::*;
();

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 10;
  localparam int N_RANDOM       = 220;  // Random-mix instructions
  localparam int DRAIN_MAX      = 200;
  localparam int PLANNED_CYCLES = 2*RESET_CYCLES + 4*N_RANDOM + 4*DRAIN_MAX;

  typedef struct packed {
    inst_kind_e kind;
    areg_t      dest;
    word_t      npc;
    word_t      value;
  } ref_entry_t;

  typedef struct packed {
    logic  wr_en;
    areg_t wr_idx;
    word_t wr_data;
    word_t npc;
  } commit_t;

  typedef struct packed {
    rob_idx_t idx;
    word_t    value;
  } pending_t;

  logic          clock;
  logic          rst;
  logic          dispatch_valid;
  inst_kind_e    dispatch_kind;
  areg_t         dispatch_dest;
  word_t         dispatch_npc;
  logic          dispatch_stall;
  rob_idx_t      dispatch_rob_idx;
  logic          complete_valid;
  rob_idx_t      complete_rob_idx;
  word_t         complete_value;
  logic          commit_valid;
  logic          commit_wr_en;
  areg_t         commit_wr_idx;
  word_t         commit_wr_data;
  word_t         commit_npc;
  error_status_e error_status;
  logic [15:0]   completed_insts;

  ref_entry_t  ref_q [$];   // Accepted, not yet retired
  pending_t    pend_q [$];  // Normal entries awaiting completion
  logic [31:0] lcg_state;
  int          errors;
  int          num_accepted;
  int          num_committed;
  int          expect_insts;
  logic        stopped;     // Halt or illegal retired
  rob_idx_t    tb_tail;
  word_t       next_npc;

  ooo_retire_core dut_i (
    .clock            (clock),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_kind    (dispatch_kind),
    .dispatch_dest    (dispatch_dest),
    .dispatch_npc     (dispatch_npc),
    .dispatch_stall   (dispatch_stall),
    .dispatch_rob_idx (dispatch_rob_idx),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .complete_value   (complete_value),
    .commit_valid     (commit_valid),
    .commit_wr_en     (commit_wr_en),
    .commit_wr_idx    (commit_wr_idx),
    .commit_wr_data   (commit_wr_data),
    .commit_npc       (commit_npc),
    .error_status     (error_status),
    .completed_insts  (completed_insts)
  );

  initial
  begin
    clock = 1'b0;
    forever
    begin
      #(CLK_PERIOD/2) clock = ~clock;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Few destinations so in-flight writers collide, with the zero register mixed in
  function automatic areg_t random_dest();
    logic [31:0] r;
    r = lcg_next();
    return (r[19:16] == 4'd0) ? areg_t'(`ZERO_REG) : areg_t'(r[25:24]);
  endfunction

  // Expected commit from the retire rules
  function automatic commit_t reference_commit(input ref_entry_t e);
    commit_t c;
    c.wr_en   = (e.kind == INST_NORMAL) && (e.dest != areg_t'(`ZERO_REG));
    c.wr_idx  = e.dest;
    c.wr_data = c.wr_en ? e.value : '0;
    c.npc     = e.npc;
    return c;
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic step(input logic disp_en, input inst_kind_e kind, input areg_t dest,
                      input logic comp_en);
    int         pick;
    pending_t   p;
    ref_entry_t e;
    @(negedge clock);
    complete_valid = 1'b0;
    // Pick before this cycle's dispatch joins the list
    if (comp_en && (pend_q.size() != 0))
    begin
      pick = int'(lcg_next() >> 8) % pend_q.size();
      p    = pend_q[pick];
      pend_q.delete(pick);
      complete_valid   = 1'b1;
      complete_rob_idx = p.idx;
      complete_value   = p.value;
    end
    dispatch_valid = disp_en;
    dispatch_kind  = kind;
    dispatch_dest  = dest;
    dispatch_npc   = next_npc;
    if (disp_en)
    begin
      next_npc = next_npc + 64'd4;  // Ignored dispatches burn an NPC too
      if (num_accepted - num_committed < `ROB_SZ)
      begin
        if (dispatch_stall !== 1'b0)
          report_error("dispatch_stall high with free entries");
        if (dispatch_rob_idx !== tb_tail)
          report_error($sformatf("dispatch_rob_idx %0d, expected %0d", dispatch_rob_idx, tb_tail));
        e.kind  = kind;
        e.dest  = dest;
        e.npc   = dispatch_npc;
        e.value = {lcg_next(), lcg_next()};
        ref_q.push_back(e);
        if (kind == INST_NORMAL)
        begin
          p.idx   = tb_tail;
          p.value = e.value;
          pend_q.push_back(p);
        end
        tb_tail++;
        num_accepted++;
      end
      else if (dispatch_stall !== 1'b1)
        report_error("dispatch_stall low with all entries occupied");
    end
  endtask

  task automatic apply_reset();
    @(negedge clock);
    rst            = 1'b1;
    dispatch_valid = 1'b0;
    complete_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    ref_q.delete();
    pend_q.delete();
    num_accepted  = 0;
    num_committed = 0;
    expect_insts  = 0;
    stopped       = 1'b0;
    tb_tail       = '0;
  endtask

  task automatic check_reset_state();
    if (commit_valid !== 1'b0 || commit_wr_en !== 1'b0 || dispatch_stall !== 1'b0)
      report_error("commit or stall strobe high after reset");
    if (error_status !== ERR_NONE || completed_insts !== 16'd0)
      report_error("status or count not cleared by reset");
  endtask

  // Completes everything pending until the buffer empties or the core stops
  task automatic drain();
    int cycles;
    cycles = 0;
    while ((ref_q.size() != 0) && !stopped && (cycles < DRAIN_MAX))
    begin
      step(1'b0, INST_NORMAL, '0, 1'b1);
      cycles++;
    end
    if ((ref_q.size() != 0) && !stopped)
    begin
      $display("Buffer did not drain within %0d cycles", DRAIN_MAX);
      errors++;
    end
  endtask

  task automatic check_status(input error_status_e want_status);
    step(1'b0, INST_NORMAL, '0, 1'b0);
    if (error_status !== want_status)
      report_error($sformatf("error_status %0d, expected %0d", error_status, want_status));
    if (completed_insts !== 16'(expect_insts))
      report_error($sformatf("completed_insts %0d, expected %0d", completed_insts, expect_insts));
  endtask

  ////////////////////////////////////////
  // Commit checker
  ////////////////////////////////////////
  always @(posedge clock)
  begin
    ref_entry_t e;
    commit_t    want;
    if (!rst && commit_valid)
    begin
      if (stopped)
        report_error("commit after the core halted");
      else if (ref_q.size() == 0)
        report_error("commit with no instruction in flight");
      else
      begin
        e    = ref_q.pop_front();
        want = reference_commit(e);
        if (commit_npc !== want.npc)
          report_error($sformatf("commit_npc %h, expected %h", commit_npc, want.npc));
        if (commit_wr_idx !== want.wr_idx)
          report_error($sformatf("commit_wr_idx %0d, expected %0d", commit_wr_idx, want.wr_idx));
        if (commit_wr_en !== want.wr_en)
          report_error($sformatf("commit_wr_en %b, expected %b", commit_wr_en, want.wr_en));
        if (e.kind == INST_NORMAL && commit_wr_data !== want.wr_data)
          report_error($sformatf("commit_wr_data %h, expected %h", commit_wr_data, want.wr_data));
        if (e.kind != INST_ILLEGAL)
          expect_insts++;
        if (e.kind != INST_NORMAL)
          stopped = 1'b1;
        num_committed++;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial
  begin
    logic [31:0] r;
    rst              = 1'b1;
    dispatch_valid   = 1'b0;
    dispatch_kind    = INST_NORMAL;
    dispatch_dest    = '0;
    dispatch_npc     = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    complete_value   = '0;
    lcg_state        = 32'hfb7a3f8d;
    errors           = 0;
    next_npc         = 64'h1000;
    apply_reset();
    check_reset_state();

    // Random mix with out-of-order completions
    while (num_accepted < N_RANDOM)
    begin
      r = lcg_next();
      step(r[28] | r[29], INST_NORMAL, random_dest(), r[30]);
    end
    drain();
    check_status(ERR_NONE);

    // Fill the buffer with nothing completing
    repeat (`ROB_SZ) step(1'b1, INST_NORMAL, random_dest(), 1'b0);
    repeat (3) step(1'b1, INST_NORMAL, random_dest(), 1'b0);
    if (dispatch_stall !== 1'b1)
      report_error("dispatch_stall low with a full buffer");
    drain();
    repeat (5) step(1'b1, INST_NORMAL, random_dest(), 1'b1);
    drain();

    // Halt with younger instructions behind it
    repeat (4) step(1'b1, INST_NORMAL, random_dest(), 1'b1);
    step(1'b1, INST_HALT, areg_t'(`ZERO_REG), 1'b1);
    repeat (3) step(1'b1, INST_NORMAL, random_dest(), 1'b1);
    drain();
    repeat (10) step(1'b0, INST_NORMAL, '0, 1'b1);
    check_status(ERR_HALTED_ON_HALT);

    // Illegal at the head after a fresh reset
    apply_reset();
    check_reset_state();
    step(1'b1, INST_ILLEGAL, random_dest(), 1'b0);
    step(1'b1, INST_NORMAL, random_dest(), 1'b1);
    drain();
    repeat (5) step(1'b0, INST_NORMAL, '0, 1'b1);
    check_status(ERR_HALTED_ON_ILLEGAL);

    $display("Checks finished with %0d errors", errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    #(20 * PLANNED_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ooo_retire.f ====
+incdir+include
source/isa_pkg.sv
source/ooo_pkg.sv
source/rename_map.sv
source/reorder_buffer.sv
source/phys_regfile.sv
source/retire_status.sv
source/ooo_retire_core.sv
dv/ooo_retire_core_tb.sv
